// File: source/csr_config.svh
// width, reset and constant-value macros for the machine-mode CSR file
`ifndef CSR_CONFIG_SVH
`define CSR_CONFIG_SVH

// register width of the RV32 core, one machine word
`define CSR_XLEN 32

// the cycle and instret counters are 64 bits on RV32 as well,
// software reads them as a low half and a high half
`define CSR_CNT_W 64

// trap vector base after reset, direct mode since the low two bits are zero
`define CSR_MTVEC_RESET 32'h0000_0100

// misa with MXL=1 for a 32-bit hart, extension bits I (bit 8) and M (bit 12)
`define CSR_MISA_VALUE 32'h4000_1100

`endif

// File: source/csr_pkg.sv
// shared word, counter and cause types plus the CSR address enum
`include "csr_config.svh"

package csr_pkg;

    // one architectural register word
    typedef logic [`CSR_XLEN-1:0] csr_word_t;

    // full-width counter value, split into two words on reads
    typedef logic [`CSR_CNT_W-1:0] csr_cnt_t;

    // exception or interrupt code as the trap controller reports it
    typedef logic [3:0] csr_cause_t;

    // addresses this CSR file knows about
    // the ID registers (mvendorid and friends) are not listed,
    // they fall into the read-zero default of the read port
    typedef enum logic [11:0] {
        // machine trap setup
        MSTATUS   = 12'h300,
        MISA      = 12'h301,
        MIE       = 12'h304,
        MTVEC     = 12'h305,
        // machine trap handling
        MSCRATCH  = 12'h340,
        MEPC      = 12'h341,
        MCAUSE    = 12'h342,
        MTVAL     = 12'h343,
        MIP       = 12'h344,
        // machine counters, low halves
        MCYCLE    = 12'hB00,
        MINSTRET  = 12'hB02,
        // machine counters, high halves
        MCYCLEH   = 12'hB80,
        MINSTRETH = 12'hB82,
        // user-level read-only aliases of the cycle counter
        CYCLE     = 12'hC00,
        CYCLEH    = 12'hC80
    } csr_addr_e;

endpackage

// File: source/csr_write_decode.sv
// software write decoder producing one write strobe per writable CSR
`timescale 1ns/1ps

module csr_write_decode (
    input  logic        we_i,
    input  logic [11:0] waddr_i,
    output logic        wr_mstatus_o,
    output logic        wr_mie_o,
    output logic        wr_mtvec_o,
    output logic        wr_mscratch_o,
    output logic        wr_mepc_o,
    output logic        wr_mcause_o,
    output logic        wr_mtval_o
);

    // this is the only address compare on the write side,
    // the register blocks just look at their own strobe
    always_comb begin
        wr_mstatus_o  = 1'b0;
        wr_mie_o      = 1'b0;
        wr_mtvec_o    = 1'b0;
        wr_mscratch_o = 1'b0;
        wr_mepc_o     = 1'b0;
        wr_mcause_o   = 1'b0;
        wr_mtval_o    = 1'b0;
        // no enable means no strobe whatever the address bus holds
        if (we_i) begin
            case (waddr_i)
                csr_pkg::MSTATUS: begin
                    wr_mstatus_o = 1'b1;
                end
                csr_pkg::MIE: begin
                    wr_mie_o = 1'b1;
                end
                csr_pkg::MTVEC: begin
                    wr_mtvec_o = 1'b1;
                end
                csr_pkg::MSCRATCH: begin
                    wr_mscratch_o = 1'b1;
                end
                csr_pkg::MEPC: begin
                    wr_mepc_o = 1'b1;
                end
                csr_pkg::MCAUSE: begin
                    wr_mcause_o = 1'b1;
                end
                csr_pkg::MTVAL: begin
                    wr_mtval_o = 1'b1;
                end
                // misa, mip and the counters are read-only here,
                // and unmapped addresses are simply ignored
                default: begin
                end
            endcase
        end
    end

endmodule

// File: source/csr_counters.sv
// free-running cycle counter and retired-instruction counter
`timescale 1ns/1ps

module csr_counters (
    input  logic              clk_i,
    input  logic              n_rst_i,
    input  logic              instret_incr_i,
    output csr_pkg::csr_cnt_t mcycle_o,
    output csr_pkg::csr_cnt_t minstret_o
);

    csr_pkg::csr_cnt_t mcycle;
    csr_pkg::csr_cnt_t minstret;

    // mcycle counts every clock edge once reset is released,
    // and it also serves the user cycle alias on the read side
    always_ff @(posedge clk_i or negedge n_rst_i) begin
        if (!n_rst_i) begin
            mcycle <= '0;
        end else begin
            mcycle <= mcycle + 1'b1;
        end
    end

    // minstret only moves on the retire strobe from writeback,
    // at most one instruction retires per cycle in this core
    always_ff @(posedge clk_i or negedge n_rst_i) begin
        if (!n_rst_i) begin
            minstret <= '0;
        end else if (instret_incr_i) begin
            minstret <= minstret + 1'b1;
        end
    end

    // both counters are read-only, software writes never reach them
    assign mcycle_o   = mcycle;
    assign minstret_o = minstret;

endmodule

// File: source/csr_trap_regs.sv
// mstatus, mtvec, mscratch, mepc, mcause and mtval with trap entry and return updates
`timescale 1ns/1ps
`include "csr_config.svh"

module csr_trap_regs (
    input  logic                clk_i,
    input  logic                n_rst_i,
    input  csr_pkg::csr_word_t  wdata_i,
    input  logic                wr_mstatus_i,
    input  logic                wr_mtvec_i,
    input  logic                wr_mscratch_i,
    input  logic                wr_mepc_i,
    input  logic                wr_mcause_i,
    input  logic                wr_mtval_i,
    input  logic                set_cause_i,
    input  logic                ie_type_i,
    input  csr_pkg::csr_cause_t trap_cause_i,
    input  logic                set_epc_i,
    input  csr_pkg::csr_word_t  epc_i,
    input  logic                set_mtval_i,
    input  csr_pkg::csr_word_t  mtval_i,
    input  logic                mstatus_ie_clear_i,
    input  logic                mstatus_ie_set_i,
    output csr_pkg::csr_word_t  mstatus_o,
    output csr_pkg::csr_word_t  mtvec_o,
    output csr_pkg::csr_word_t  mscratch_o,
    output csr_pkg::csr_word_t  mepc_o,
    output csr_pkg::csr_word_t  mcause_o,
    output csr_pkg::csr_word_t  mtval_o,
    output logic                mstatus_ie_o
);

    // global machine interrupt enable (MIE) and its saved copy (MPIE)
    logic               mstatus_ie;
    logic               mstatus_pie;
    csr_pkg::csr_word_t mtvec;
    csr_pkg::csr_word_t mscratch;
    csr_pkg::csr_word_t mepc;
    csr_pkg::csr_word_t mcause;
    csr_pkg::csr_word_t mtval;

    // software write first, then trap entry, then trap return
    // MPIE comes up as 1 so the first mret after reset enables interrupts
    always_ff @(posedge clk_i or negedge n_rst_i) begin
        if (!n_rst_i) begin
            mstatus_ie  <= 1'b0;
            mstatus_pie <= 1'b1;
        end else if (wr_mstatus_i) begin
            mstatus_ie  <= wdata_i[3];
            mstatus_pie <= wdata_i[7];
        end else if (mstatus_ie_clear_i) begin
            // trap entry saves the enable and masks further interrupts
            mstatus_pie <= mstatus_ie;
            mstatus_ie  <= 1'b0;
        end else if (mstatus_ie_set_i) begin
            // mret brings the saved enable back
            mstatus_ie  <= mstatus_pie;
            mstatus_pie <= 1'b1;
        end
    end

    // mstatus layout has MPP at 12:11 (always machine mode), MPIE at 7, MIE at 3
    assign mstatus_o = csr_pkg::csr_word_t'({2'b11, 3'b000, mstatus_pie, 3'b000, mstatus_ie,
                                            3'b000});
    assign mstatus_ie_o = mstatus_ie;

    // trap vector base and mode, fully writable by software
    always_ff @(posedge clk_i or negedge n_rst_i) begin
        if (!n_rst_i) begin
            mtvec <= `CSR_MTVEC_RESET;
        end else if (wr_mtvec_i) begin
            mtvec <= wdata_i;
        end
    end

    // scratch word for the trap handler, hardware never touches it
    always_ff @(posedge clk_i or negedge n_rst_i) begin
        if (!n_rst_i) begin
            mscratch <= '0;
        end else if (wr_mscratch_i) begin
            mscratch <= wdata_i;
        end
    end

    // the hardware epc wins over a software write in the same cycle
    // only IALIGN=32 is supported, so the two low bits stay zero
    always_ff @(posedge clk_i or negedge n_rst_i) begin
        if (!n_rst_i) begin
            mepc <= '0;
        end else if (set_epc_i) begin
            mepc <= {epc_i[`CSR_XLEN-1:2], 2'b00};
        end else if (wr_mepc_i) begin
            mepc <= {wdata_i[`CSR_XLEN-1:2], 2'b00};
        end
    end

    // the trap controller writes the interrupt flag in the top bit and the code
    // in the bottom nibble, clearing the rest, while software may store any word
    always_ff @(posedge clk_i or negedge n_rst_i) begin
        if (!n_rst_i) begin
            mcause <= '0;
        end else if (set_cause_i) begin
            mcause <= {ie_type_i, {(`CSR_XLEN-5){1'b0}}, trap_cause_i};
        end else if (wr_mcause_i) begin
            mcause <= wdata_i;
        end
    end

    // faulting address or instruction, again hardware before software
    always_ff @(posedge clk_i or negedge n_rst_i) begin
        if (!n_rst_i) begin
            mtval <= '0;
        end else if (set_mtval_i) begin
            mtval <= mtval_i;
        end else if (wr_mtval_i) begin
            mtval <= wdata_i;
        end
    end

    assign mtvec_o    = mtvec;
    assign mscratch_o = mscratch;
    assign mepc_o     = mepc;
    assign mcause_o   = mcause;
    assign mtval_o    = mtval;

endmodule

// File: source/csr_irq_regs.sv
// mie enable bits written by software and mip pending bits sampled from the irq lines
`timescale 1ns/1ps

module csr_irq_regs (
    input  logic               clk_i,
    input  logic               n_rst_i,
    input  csr_pkg::csr_word_t wdata_i,
    input  logic               wr_mie_i,
    input  logic               irq_software_i,
    input  logic               irq_timer_i,
    input  logic               irq_external_i,
    output csr_pkg::csr_word_t mie_o,
    output csr_pkg::csr_word_t mip_o,
    output logic               mie_external_o,
    output logic               mie_timer_o,
    output logic               mie_sw_o,
    output logic               mip_external_o,
    output logic               mip_timer_o,
    output logic               mip_sw_o
);

    // both words only implement the machine-level bits: external at 11,
    // timer at 7 and software at 3, everything else reads zero
    logic mie_external;
    logic mie_timer;
    logic mie_sw;
    logic mip_external;
    logic mip_timer;
    logic mip_sw;

    always_ff @(posedge clk_i or negedge n_rst_i) begin
        if (!n_rst_i) begin
            mie_external <= 1'b0;
            mie_timer    <= 1'b0;
            mie_sw       <= 1'b0;
        end else if (wr_mie_i) begin
            mie_external <= wdata_i[11];
            mie_timer    <= wdata_i[7];
            mie_sw       <= wdata_i[3];
        end
    end

    // the pending bits follow the irq levels one edge late,
    // software writes to mip have no effect
    always_ff @(posedge clk_i or negedge n_rst_i) begin
        if (!n_rst_i) begin
            mip_external <= 1'b0;
            mip_timer    <= 1'b0;
            mip_sw       <= 1'b0;
        end else begin
            mip_external <= irq_external_i;
            mip_timer    <= irq_timer_i;
            mip_sw       <= irq_software_i;
        end
    end

    assign mie_o = csr_pkg::csr_word_t'({mie_external, 3'b000, mie_timer, 3'b000, mie_sw, 3'b000});
    assign mip_o = csr_pkg::csr_word_t'({mip_external, 3'b000, mip_timer, 3'b000, mip_sw, 3'b000});

    assign mie_external_o = mie_external;
    assign mie_timer_o    = mie_timer;
    assign mie_sw_o       = mie_sw;
    assign mip_external_o = mip_external;
    assign mip_timer_o    = mip_timer;
    assign mip_sw_o       = mip_sw;

endmodule

// File: source/csr_read_mux.sv
// combinational CSR read multiplexer with write-to-read bypass
`timescale 1ns/1ps
`include "csr_config.svh"

module csr_read_mux (
    input  logic [11:0]        raddr_i,
    input  logic               we_i,
    input  logic [11:0]        waddr_i,
    input  csr_pkg::csr_word_t wdata_i,
    input  csr_pkg::csr_word_t mstatus_i,
    input  csr_pkg::csr_word_t mie_i,
    input  csr_pkg::csr_word_t mtvec_i,
    input  csr_pkg::csr_word_t mscratch_i,
    input  csr_pkg::csr_word_t mepc_i,
    input  csr_pkg::csr_word_t mcause_i,
    input  csr_pkg::csr_word_t mtval_i,
    input  csr_pkg::csr_word_t mip_i,
    input  csr_pkg::csr_cnt_t  mcycle_i,
    input  csr_pkg::csr_cnt_t  minstret_i,
    output csr_pkg::csr_word_t rdata_o
);

    // the register contents selected by address alone
    csr_pkg::csr_word_t reg_data;

    always_comb begin
        case (raddr_i)
            csr_pkg::MSTATUS: begin
                reg_data = mstatus_i;
            end
            csr_pkg::MISA: begin
                reg_data = `CSR_MISA_VALUE;
            end
            csr_pkg::MIE: begin
                reg_data = mie_i;
            end
            csr_pkg::MTVEC: begin
                reg_data = mtvec_i;
            end
            csr_pkg::MSCRATCH: begin
                reg_data = mscratch_i;
            end
            csr_pkg::MEPC: begin
                reg_data = mepc_i;
            end
            csr_pkg::MCAUSE: begin
                reg_data = mcause_i;
            end
            csr_pkg::MTVAL: begin
                reg_data = mtval_i;
            end
            csr_pkg::MIP: begin
                reg_data = mip_i;
            end
            // user cycle and cycleh share the machine counter
            csr_pkg::MCYCLE, csr_pkg::CYCLE: begin
                reg_data = mcycle_i[`CSR_XLEN-1:0];
            end
            csr_pkg::MCYCLEH, csr_pkg::CYCLEH: begin
                reg_data = mcycle_i[`CSR_CNT_W-1:`CSR_XLEN];
            end
            csr_pkg::MINSTRET: begin
                reg_data = minstret_i[`CSR_XLEN-1:0];
            end
            csr_pkg::MINSTRETH: begin
                reg_data = minstret_i[`CSR_CNT_W-1:`CSR_XLEN];
            end
            // the ID registers and anything unmapped read as zero
            default: begin
                reg_data = '0;
            end
        endcase
    end

    // a write in the same cycle to the address being read is forwarded,
    // which holds even for read-only addresses whose register keeps its value
    assign rdata_o = (we_i && (waddr_i == raddr_i)) ? wdata_i : reg_data;

endmodule

// File: source/csr_file.sv
// top level of the machine-mode CSR file connecting decoder, register blocks and read port
`timescale 1ns/1ps

module csr_file (
    input  logic                clk_i,
    input  logic                n_rst_i,
    input  logic                irq_software_i,
    input  logic                irq_timer_i,
    input  logic                irq_external_i,
    input  logic [11:0]         raddr_i,
    output csr_pkg::csr_word_t  rdata_o,
    input  logic                we_i,
    input  logic [11:0]         waddr_i,
    input  csr_pkg::csr_word_t  wdata_i,
    input  logic                instret_incr_i,
    input  logic                ie_type_i,
    input  logic                set_cause_i,
    input  csr_pkg::csr_cause_t trap_cause_i,
    input  logic                set_epc_i,
    input  csr_pkg::csr_word_t  epc_i,
    input  logic                set_mtval_i,
    input  csr_pkg::csr_word_t  mtval_i,
    input  logic                mstatus_ie_clear_i,
    input  logic                mstatus_ie_set_i,
    output logic                mstatus_ie_o,
    output logic                mie_external_o,
    output logic                mie_timer_o,
    output logic                mie_sw_o,
    output logic                mip_external_o,
    output logic                mip_timer_o,
    output logic                mip_sw_o,
    output csr_pkg::csr_word_t  mtvec_o,
    output csr_pkg::csr_word_t  epc_o
);

    // per-register write strobes from the decoder
    logic wr_mstatus;
    logic wr_mie;
    logic wr_mtvec;
    logic wr_mscratch;
    logic wr_mepc;
    logic wr_mcause;
    logic wr_mtval;

    // register contents heading for the read port
    csr_pkg::csr_word_t mstatus;
    csr_pkg::csr_word_t mscratch;
    csr_pkg::csr_word_t mcause;
    csr_pkg::csr_word_t mtval;
    csr_pkg::csr_word_t mie;
    csr_pkg::csr_word_t mip;
    csr_pkg::csr_cnt_t  mcycle;
    csr_pkg::csr_cnt_t  minstret;

    csr_write_decode csr_write_decode_inst (
        .we_i          (we_i),
        .waddr_i       (waddr_i),
        .wr_mstatus_o  (wr_mstatus),
        .wr_mie_o      (wr_mie),
        .wr_mtvec_o    (wr_mtvec),
        .wr_mscratch_o (wr_mscratch),
        .wr_mepc_o     (wr_mepc),
        .wr_mcause_o   (wr_mcause),
        .wr_mtval_o    (wr_mtval)
    );

    csr_counters csr_counters_inst (
        .clk_i          (clk_i),
        .n_rst_i        (n_rst_i),
        .instret_incr_i (instret_incr_i),
        .mcycle_o       (mcycle),
        .minstret_o     (minstret)
    );

    // mtvec and mepc go straight out to the fetch redirect logic
    csr_trap_regs csr_trap_regs_inst (
        .clk_i              (clk_i),
        .n_rst_i            (n_rst_i),
        .wdata_i            (wdata_i),
        .wr_mstatus_i       (wr_mstatus),
        .wr_mtvec_i         (wr_mtvec),
        .wr_mscratch_i      (wr_mscratch),
        .wr_mepc_i          (wr_mepc),
        .wr_mcause_i        (wr_mcause),
        .wr_mtval_i         (wr_mtval),
        .set_cause_i        (set_cause_i),
        .ie_type_i          (ie_type_i),
        .trap_cause_i       (trap_cause_i),
        .set_epc_i          (set_epc_i),
        .epc_i              (epc_i),
        .set_mtval_i        (set_mtval_i),
        .mtval_i            (mtval_i),
        .mstatus_ie_clear_i (mstatus_ie_clear_i),
        .mstatus_ie_set_i   (mstatus_ie_set_i),
        .mstatus_o          (mstatus),
        .mtvec_o            (mtvec_o),
        .mscratch_o         (mscratch),
        .mepc_o             (epc_o),
        .mcause_o           (mcause),
        .mtval_o            (mtval),
        .mstatus_ie_o       (mstatus_ie_o)
    );

    csr_irq_regs csr_irq_regs_inst (
        .clk_i          (clk_i),
        .n_rst_i        (n_rst_i),
        .wdata_i        (wdata_i),
        .wr_mie_i       (wr_mie),
        .irq_software_i (irq_software_i),
        .irq_timer_i    (irq_timer_i),
        .irq_external_i (irq_external_i),
        .mie_o          (mie),
        .mip_o          (mip),
        .mie_external_o (mie_external_o),
        .mie_timer_o    (mie_timer_o),
        .mie_sw_o       (mie_sw_o),
        .mip_external_o (mip_external_o),
        .mip_timer_o    (mip_timer_o),
        .mip_sw_o       (mip_sw_o)
    );

    // mepc is read back from the same wire that drives epc_o
    csr_read_mux csr_read_mux_inst (
        .raddr_i    (raddr_i),
        .we_i       (we_i),
        .waddr_i    (waddr_i),
        .wdata_i    (wdata_i),
        .mstatus_i  (mstatus),
        .mie_i      (mie),
        .mtvec_i    (mtvec_o),
        .mscratch_i (mscratch),
        .mepc_i     (epc_o),
        .mcause_i   (mcause),
        .mtval_i    (mtval),
        .mip_i      (mip),
        .mcycle_i   (mcycle),
        .minstret_i (minstret),
        .rdata_o    (rdata_o)
    );

endmodule

// File: tests/csr_file_tb.sv
// testbench for the CSR file with shadow reference model, compare process and watchdog
`timescale 1ns/1ps
`include "csr_config.svh"

module csr_file_tb;

    // the watchdog allows twice this rough cycle count of all tests
    localparam int cycle_budget = 600;

    logic clk_i = 1'b0;
    logic n_rst_i, irq_software_i, irq_timer_i, irq_external_i;
    logic [11:0] raddr_i, waddr_i;
    logic we_i, instret_incr_i, ie_type_i, set_cause_i, set_epc_i, set_mtval_i;
    logic mstatus_ie_clear_i, mstatus_ie_set_i;
    logic [3:0] trap_cause_i;
    logic [31:0] wdata_i, epc_i, mtval_i, rdata_o, mtvec_o, epc_o;
    logic mstatus_ie_o, mie_external_o, mie_timer_o, mie_sw_o;
    logic mip_external_o, mip_timer_o, mip_sw_o;

    // shadow copy of the architectural state
    logic sh_ie, sh_pie;
    logic [31:0] sh_mtvec, sh_mscratch, sh_mepc, sh_mcause, sh_mtval, sh_mie, sh_mip;
    logic [63:0] sh_cycle, sh_instret;
    logic [31:0] exp_word, seed_val, c0, c1, c2, i0, i1;
    int error_count = 0;
    int pulses;

    csr_file csr_file_inst (.*);

    always #5 clk_i = ~clk_i;

    // the shadow model applies the write masks, strobe priorities and trap rules
    always @(posedge clk_i or negedge n_rst_i) begin
        if (!n_rst_i) begin
            sh_ie = 1'b0;
            sh_pie = 1'b1;
            sh_mtvec = `CSR_MTVEC_RESET;
            {sh_mscratch, sh_mepc, sh_mcause, sh_mtval, sh_mie, sh_mip} = '0;
            sh_cycle = '0;
            sh_instret = '0;
        end else begin
            // software write beats clear, clear beats set
            if (we_i && waddr_i == csr_pkg::MSTATUS) begin
                sh_ie = wdata_i[3];
                sh_pie = wdata_i[7];
            end else if (mstatus_ie_clear_i) begin
                sh_pie = sh_ie;
                sh_ie = 1'b0;
            end else if (mstatus_ie_set_i) begin
                sh_ie = sh_pie;
                sh_pie = 1'b1;
            end
            if (we_i && waddr_i == csr_pkg::MTVEC) sh_mtvec = wdata_i;
            if (we_i && waddr_i == csr_pkg::MSCRATCH) sh_mscratch = wdata_i;
            if (we_i && waddr_i == csr_pkg::MIE) sh_mie = wdata_i & 32'h0000_0888;
            // trap strobes win over software for mepc, mcause and mtval
            if (set_epc_i) sh_mepc = epc_i & ~32'h3;
            else if (we_i && waddr_i == csr_pkg::MEPC) sh_mepc = wdata_i & ~32'h3;
            if (set_cause_i) sh_mcause = {ie_type_i, 27'b0, trap_cause_i};
            else if (we_i && waddr_i == csr_pkg::MCAUSE) sh_mcause = wdata_i;
            if (set_mtval_i) sh_mtval = mtval_i;
            else if (we_i && waddr_i == csr_pkg::MTVAL) sh_mtval = wdata_i;
            sh_mip = {20'b0, irq_external_i, 3'b0, irq_timer_i, 3'b0, irq_software_i, 3'b0};
            sh_cycle = sh_cycle + 1;
            if (instret_incr_i) sh_instret = sh_instret + 1;
        end
    end

    // the expected read word is zero wherever nothing is mapped
    function automatic logic [31:0] expected_rdata(input logic [11:0] addr);
        case (addr)
            csr_pkg::MSTATUS: return {19'b0, 2'b11, 3'b0, sh_pie, 3'b0, sh_ie, 3'b0};
            csr_pkg::MISA: return `CSR_MISA_VALUE;
            csr_pkg::MIE: return sh_mie;
            csr_pkg::MTVEC: return sh_mtvec;
            csr_pkg::MSCRATCH: return sh_mscratch;
            csr_pkg::MEPC: return sh_mepc;
            csr_pkg::MCAUSE: return sh_mcause;
            csr_pkg::MTVAL: return sh_mtval;
            csr_pkg::MIP: return sh_mip;
            csr_pkg::MCYCLE, csr_pkg::CYCLE: return sh_cycle[31:0];
            csr_pkg::MCYCLEH, csr_pkg::CYCLEH: return sh_cycle[63:32];
            csr_pkg::MINSTRET: return sh_instret[31:0];
            csr_pkg::MINSTRETH: return sh_instret[63:32];
            default: return 32'h0;
        endcase
    endfunction

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            error_count++;
            $display("ERROR at %0t ns: %s expected %h, actual %h", $time, name, exp, act);
            $display(">>> FAIL");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    // inputs change 1 ns after the rising edge
    task automatic step_cycle();
        @(posedge clk_i);
        #1;
    endtask

    task automatic read_word(input logic [11:0] addr, output logic [31:0] value);
        raddr_i = addr;
        @(negedge clk_i);
        value = rdata_o;
        step_cycle();
    endtask

    task automatic read_expect(input logic [11:0] addr, input logic [31:0] exp);
        raddr_i = addr;
        @(negedge clk_i);
        check_word("rdata_o", exp, rdata_o);
        step_cycle();
    endtask

    // all trap strobes at once plus a competing software write to mepc
    // prior_ie is the enable that the stimulus left in mstatus before the trap
    task automatic trap_entry(input logic prior_ie);
        logic [31:0] rnd, epc_v, tval_v;
        rnd = $urandom;
        epc_v = $urandom;
        tval_v = $urandom;
        {set_cause_i, set_epc_i, set_mtval_i, mstatus_ie_clear_i} = 4'b1111;
        ie_type_i = rnd[0];
        trap_cause_i = rnd[7:4];
        epc_i = epc_v;
        mtval_i = tval_v;
        we_i = 1'b1;
        waddr_i = csr_pkg::MEPC;
        wdata_i = $urandom;
        raddr_i = csr_pkg::MEPC;
        step_cycle();
        {set_cause_i, set_epc_i, set_mtval_i, mstatus_ie_clear_i, we_i} = '0;
        read_expect(csr_pkg::MEPC, {epc_v[31:2], 2'b00});
        read_expect(csr_pkg::MCAUSE, {rnd[0], 27'b0, rnd[7:4]});
        read_expect(csr_pkg::MTVAL, tval_v);
        check_word("mstatus_ie_o", 32'h0, {31'b0, mstatus_ie_o});
        read_expect(csr_pkg::MSTATUS, {19'b0, 2'b11, 3'b0, prior_ie, 7'b0});
    endtask

    // every output is checked against the shadow model in mid-cycle
    always @(negedge clk_i) begin
        if (n_rst_i) begin
            if (we_i && waddr_i == raddr_i) exp_word = wdata_i;
            else exp_word = expected_rdata(raddr_i);
            check_word("rdata_o", exp_word, rdata_o);
            check_word("mstatus_ie_o", {31'b0, sh_ie}, {31'b0, mstatus_ie_o});
            check_word("mie_external_o", {31'b0, sh_mie[11]}, {31'b0, mie_external_o});
            check_word("mie_timer_o", {31'b0, sh_mie[7]}, {31'b0, mie_timer_o});
            check_word("mie_sw_o", {31'b0, sh_mie[3]}, {31'b0, mie_sw_o});
            check_word("mip_external_o", {31'b0, sh_mip[11]}, {31'b0, mip_external_o});
            check_word("mip_timer_o", {31'b0, sh_mip[7]}, {31'b0, mip_timer_o});
            check_word("mip_sw_o", {31'b0, sh_mip[3]}, {31'b0, mip_sw_o});
            check_word("mtvec_o", sh_mtvec, mtvec_o);
            check_word("epc_o", sh_mepc, epc_o);
        end
    end

    initial begin
        #(2 * cycle_budget * 10);
        $display("timeout: the tests did not finish within %0d cycles", 2 * cycle_budget);
        $display(">>> FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin
        logic [11:0] wr_addrs [10];
        logic [11:0] a;
        wr_addrs = '{csr_pkg::MSTATUS, csr_pkg::MIE, csr_pkg::MTVEC, csr_pkg::MSCRATCH,
                     csr_pkg::MEPC, csr_pkg::MCAUSE, csr_pkg::MTVAL, csr_pkg::MISA,
                     csr_pkg::MIP, csr_pkg::MCYCLE};
        seed_val = $urandom(32'hb4a55025);
        n_rst_i = 1'b0;
        {irq_software_i, irq_timer_i, irq_external_i, we_i, instret_incr_i} = '0;
        {ie_type_i, set_cause_i, set_epc_i, set_mtval_i} = '0;
        {mstatus_ie_clear_i, mstatus_ie_set_i} = '0;
        raddr_i = csr_pkg::MSTATUS;
        waddr_i = '0;
        wdata_i = '0;
        trap_cause_i = '0;
        epc_i = '0;
        mtval_i = '0;
        repeat (8) @(posedge clk_i);
        #1 n_rst_i = 1'b1;

        // reset values
        read_expect(csr_pkg::MSTATUS, 32'h0000_1880);
        read_expect(csr_pkg::MTVEC, `CSR_MTVEC_RESET);
        read_expect(csr_pkg::MISA, `CSR_MISA_VALUE);
        foreach (wr_addrs[i]) begin
            if (i == 1 || (i >= 3 && i <= 6) || i == 8) read_expect(wr_addrs[i], 32'h0);
        end
        read_expect(12'hF11, 32'h0);
        read_expect(12'h7C0 | 12'($urandom % 64), 32'h0);

        // random writes are seen through the bypass in the write cycle
        // and read back by the compare process one cycle later
        repeat (200) begin
            a = wr_addrs[$urandom % 10];
            we_i = 1'b1;
            waddr_i = a;
            wdata_i = $urandom;
            raddr_i = a;
            @(negedge clk_i);
            check_word("rdata_o", wdata_i, rdata_o);
            step_cycle();
            we_i = 1'b0;
            step_cycle();
        end

        // trap entry from an enabled state and then from a masked one
        we_i = 1'b1;
        waddr_i = csr_pkg::MSTATUS;
        wdata_i = 32'h0000_0008;
        step_cycle();
        we_i = 1'b0;
        trap_entry(1'b1);
        trap_entry(1'b0);

        // trap return restores the enable from MPIE
        we_i = 1'b1;
        waddr_i = csr_pkg::MSTATUS;
        wdata_i = 32'h0000_0080;
        step_cycle();
        we_i = 1'b0;
        mstatus_ie_set_i = 1'b1;
        step_cycle();
        mstatus_ie_set_i = 1'b0;
        check_word("mstatus_ie_o", 32'h1, {31'b0, mstatus_ie_o});
        read_expect(csr_pkg::MSTATUS, 32'h0000_1888);
        // a software write in the same cycle as a clear takes effect
        we_i = 1'b1;
        wdata_i = $urandom;
        mstatus_ie_clear_i = 1'b1;
        step_cycle();
        {we_i, mstatus_ie_clear_i} = '0;
        read_expect(csr_pkg::MSTATUS, 32'h0000_1800 | (wdata_i & 32'h0000_0088));

        // the compare process follows the outputs while irq levels and mie change
        for (int k = 0; k < 30; k++) begin
            {irq_external_i, irq_timer_i, irq_software_i} = 3'($urandom);
            we_i = k[0];
            waddr_i = csr_pkg::MIE;
            wdata_i = $urandom;
            raddr_i = csr_pkg::MIP;
            step_cycle();
        end
        we_i = 1'b0;

        // mcycle difference over 20 cycles, the aliases and the high halves
        read_word(csr_pkg::MCYCLE, c0);
        repeat (19) step_cycle();
        read_word(csr_pkg::MCYCLE, c1);
        check_word("mcycle delta", 32'd20, c1 - c0);
        read_word(csr_pkg::CYCLE, c2);
        check_word("cycle alias", c1 + 1, c2);
        read_expect(csr_pkg::CYCLEH, 32'(({32'h0, c0} + 64'd22) >> 32));
        read_expect(csr_pkg::MCYCLEH, 32'(({32'h0, c0} + 64'd23) >> 32));

        // minstret counts only the driven retire pulses
        read_word(csr_pkg::MINSTRET, i0);
        pulses = 0;
        repeat (40) begin
            instret_incr_i = $urandom % 2;
            pulses += instret_incr_i;
            step_cycle();
        end
        instret_incr_i = 1'b0;
        read_word(csr_pkg::MINSTRET, i1);
        check_word("minstret delta", 32'(pulses), i1 - i0);
        read_expect(csr_pkg::MINSTRETH, 32'(({32'h0, i0} + 64'(pulses)) >> 32));

        if (error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+source
source/csr_pkg.sv
source/csr_write_decode.sv
source/csr_counters.sv
source/csr_trap_regs.sv
source/csr_irq_regs.sv
source/csr_read_mux.sv
source/csr_file.sv
tests/csr_file_tb.sv
